// File: source/stepper_pkg.sv
package stepper_pkg;

    // ====================
    // Widths
    // ====================

    typedef logic [7:0] current_t;     // Coil current magnitude, 255 is full scale.
    typedef logic [6:0] phase_t;       // Electrical phase, 128 microsteps per cycle.
    typedef logic [5:0] quarter_idx_t; // Index into the quarter-wave table, 0 to 32.
    typedef logic [9:0] long_time_t;   // Off-time and fast decay durations.
    typedef logic [7:0] short_time_t;  // Blanking, minimum on-time and pump period.
    typedef logic [11:0] on_count_t;   // Wide enough to reach max_on_cycles.
    typedef logic [2:0] dead_count_t;  // Wide enough to reach dead_cycles.

    typedef struct packed {
        current_t magnitude;
        logic negative;
    } coil_target_t;

    typedef struct packed {
        long_time_t offtime;
        short_time_t blanktime;
        long_time_t fastdecay_time;
        short_time_t min_on_time;
    } chop_config_t;

    // Switch requests for the two legs of one H-bridge.
    typedef struct packed {
        logic [1:0] high;
        logic [1:0] low;
    } bridge_switches_t;

    typedef enum logic [1:0] {
        mode_off,
        mode_forward,
        mode_reverse,
        mode_slow_decay
    } bridge_mode_t;

    typedef enum logic [1:0] {
        st_idle,
        st_on,
        st_fast_decay,
        st_slow_decay
    } chop_state_t;

    // ====================
    // Constants
    // ====================

    // First quarter of a sine, 255 * sin(pi/2 * i/32).
    localparam current_t sine_table [0:32] = '{
        8'd0,   8'd13,  8'd25,  8'd37,  8'd50,  8'd62,  8'd74,  8'd86,
        8'd98,  8'd109, 8'd120, 8'd131, 8'd142, 8'd152, 8'd162, 8'd171,
        8'd180, 8'd189, 8'd197, 8'd205, 8'd212, 8'd219, 8'd225, 8'd231,
        8'd236, 8'd240, 8'd244, 8'd247, 8'd250, 8'd252, 8'd254, 8'd255,
        8'd255
    };

    localparam int dead_cycles = 4;
    localparam int max_on_cycles = 4095;

endpackage

// File: source/step_sequencer.sv
`timescale 1ns/1ps

module step_sequencer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      step,
    input  logic                      dir,
    input  logic                      enable,
    output stepper_pkg::coil_target_t target_a,
    output stepper_pkg::coil_target_t target_b
);

    logic step_q;
    logic step_prev;
    logic step_rise;
    stepper_pkg::phase_t phase;
    stepper_pkg::phase_t phase_b;

    // Folds a phase into the quarter-wave table and returns the signed target.
    function automatic stepper_pkg::coil_target_t fold_phase(input stepper_pkg::phase_t p);
        stepper_pkg::quarter_idx_t remainder;
        stepper_pkg::quarter_idx_t idx;
        stepper_pkg::coil_target_t result;
        remainder = {1'b0, p[4:0]};
        if (p[5]) begin
            idx = 6'd32 - remainder; // Quadrants 1 and 3 run the table backwards.
        end else begin
            idx = remainder;
        end
        result.magnitude = stepper_pkg::sine_table[idx];
        result.negative = p[6]; // Second half of the cycle is negative.
        return result;
    endfunction

    assign step_rise = step_q & ~step_prev;
    assign phase_b = phase + 7'd32; // Cosine leads sine by a quarter cycle.

    // ====================
    // Step edge and phase
    // ====================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_q <= 1'b0;
            step_prev <= 1'b0;
            phase <= '0;
        end else begin
            step_q <= step;
            step_prev <= step_q;
            if (step_rise && enable) begin
                if (dir) begin
                    phase <= phase + 1'b1;
                end else begin
                    phase <= phase - 1'b1; // Wraps from 0 to 127.
                end
            end
        end
    end

    // Targets follow the phase one clock later.
    always_ff @(posedge clk) begin
        target_a <= fold_phase(phase);
        target_b <= fold_phase(phase_b);
    end

endmodule

// File: source/reference_pwm.sv
`timescale 1ns/1ps

module reference_pwm (
    input  logic                  clk,
    input  logic                  resetn,
    input  stepper_pkg::current_t duty,
    output logic                  pwm
);

    stepper_pkg::current_t count;
    stepper_pkg::current_t duty_q;
    stepper_pkg::current_t active_duty;

    // The new duty takes effect from the first count of a period.
    assign active_duty = (count == '0) ? duty : duty_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
            duty_q <= '0;
            pwm <= 1'b0;
        end else begin
            count <= count + 1'b1; // Free running, period of 256 clocks.
            if (count == '0) begin
                duty_q <= duty;
            end
            pwm <= (count < active_duty);
        end
    end

endmodule

// File: source/coil_chopper.sv
`timescale 1ns/1ps

module coil_chopper (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      enable,
    input  stepper_pkg::coil_target_t target,
    input  stepper_pkg::chop_config_t chop_config,
    input  logic                      over_current,
    output stepper_pkg::bridge_mode_t mode,
    output logic                      overtime
);

    stepper_pkg::chop_state_t state;
    stepper_pkg::chop_state_t next_state;
    stepper_pkg::on_count_t on_count;
    stepper_pkg::long_time_t off_count;
    stepper_pkg::short_time_t hold_time;
    logic [10:0] off_elapsed;
    logic zero_target;
    logic drive_negative;
    logic next_negative;
    logic entering_on;
    logic entering_off;
    logic in_off;

    assign zero_target = (target.magnitude == '0);
    assign off_elapsed = {1'b0, off_count} + 11'd1;

    // The comparator is ignored until both blanking and minimum on-time are over.
    assign hold_time = (chop_config.blanktime > chop_config.min_on_time)
        ? chop_config.blanktime : chop_config.min_on_time;

    // ====================
    // Next state
    // ====================

    always_comb begin
        next_state = state;
        case (state)
            stepper_pkg::st_idle: begin
                next_state = zero_target ? stepper_pkg::st_slow_decay : stepper_pkg::st_on;
            end
            stepper_pkg::st_on: begin
                if (zero_target) begin
                    next_state = stepper_pkg::st_slow_decay;
                end else if (on_count >= stepper_pkg::on_count_t'(hold_time) && over_current) begin
                    next_state = stepper_pkg::st_fast_decay;
                end
            end
            stepper_pkg::st_fast_decay: begin
                if (off_elapsed >= {1'b0, chop_config.fastdecay_time}) begin
                    next_state = stepper_pkg::st_slow_decay;
                end
            end
            stepper_pkg::st_slow_decay: begin
                // Off-time runs from the start of fast decay.
                if (!zero_target && off_elapsed >= {1'b0, chop_config.offtime}) begin
                    next_state = stepper_pkg::st_on;
                end
            end
            default: next_state = stepper_pkg::st_idle;
        endcase
        if (!enable) begin
            next_state = stepper_pkg::st_idle;
        end
    end

    assign entering_on = (next_state == stepper_pkg::st_on) && (state != stepper_pkg::st_on);
    assign in_off = (state == stepper_pkg::st_fast_decay) || (state == stepper_pkg::st_slow_decay);
    assign entering_off = !in_off && ((next_state == stepper_pkg::st_fast_decay) ||
        (next_state == stepper_pkg::st_slow_decay));

    // Polarity is taken once per chopping cycle and held through the decay.
    assign next_negative = entering_on ? target.negative : drive_negative;

    // ====================
    // State, counters, mode
    // ====================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= stepper_pkg::st_idle;
            on_count <= '0;
            off_count <= '0;
            drive_negative <= 1'b0;
            mode <= stepper_pkg::mode_off;
        end else begin
            state <= next_state;
            drive_negative <= next_negative;
            if (entering_on) begin
                on_count <= '0;
            end else if (on_count != '1) begin
                on_count <= on_count + 1'b1; // Saturates at max_on_cycles.
            end
            if (entering_off) begin
                off_count <= '0;
            end else if (off_count != '1) begin
                off_count <= off_count + 1'b1;
            end
            case (next_state)
                stepper_pkg::st_on: begin
                    mode <= next_negative ? stepper_pkg::mode_reverse : stepper_pkg::mode_forward;
                end
                stepper_pkg::st_fast_decay: begin
                    // Driving against the current returns it to the supply.
                    mode <= next_negative ? stepper_pkg::mode_forward : stepper_pkg::mode_reverse;
                end
                stepper_pkg::st_slow_decay: mode <= stepper_pkg::mode_slow_decay;
                default: mode <= stepper_pkg::mode_off;
            endcase
        end
    end

    assign overtime = (state == stepper_pkg::st_on) &&
        (on_count == stepper_pkg::on_count_t'(stepper_pkg::max_on_cycles));

endmodule

// File: source/gate_drive.sv
`timescale 1ns/1ps

module gate_drive (
    input  logic                      clk,
    input  logic                      resetn,
    input  stepper_pkg::bridge_mode_t mode_a,
    input  stepper_pkg::bridge_mode_t mode_b,
    input  logic                      overtime_a,
    input  logic                      overtime_b,
    input  stepper_pkg::short_time_t  chargepump_period,
    input  logic                      invert_highside,
    input  logic                      invert_lowside,
    output logic [3:0]                s_h,
    output logic [3:0]                s_l,
    output logic                      chargepump_pin,
    output logic                      fault
);

    stepper_pkg::bridge_switches_t want_a;
    stepper_pkg::bridge_switches_t want_b;
    logic [3:0] want_h;
    logic [3:0] want_l;
    logic [3:0] h_q;
    logic [3:0] l_q;
    stepper_pkg::dead_count_t off_h [4];
    stepper_pkg::dead_count_t off_l [4];
    logic fault_q;
    logic fault_next;
    stepper_pkg::short_time_t cp_count;
    logic cp_q;

    function automatic stepper_pkg::bridge_switches_t decode_mode(
        input stepper_pkg::bridge_mode_t m
    );
        stepper_pkg::bridge_switches_t sw;
        sw = '0;
        case (m)
            stepper_pkg::mode_forward: begin
                sw.high[0] = 1'b1;
                sw.low[1] = 1'b1;
            end
            stepper_pkg::mode_reverse: begin
                sw.high[1] = 1'b1;
                sw.low[0] = 1'b1;
            end
            stepper_pkg::mode_slow_decay: sw.low = 2'b11; // Both low sides recirculate.
            default: sw = '0;
        endcase
        return sw;
    endfunction

    always_comb begin
        want_a = decode_mode(mode_a);
        want_b = decode_mode(mode_b);
        want_h = {want_b.high, want_a.high}; // Coil B sits on bits 2 and 3.
        want_l = {want_b.low, want_a.low};
    end

    // Switches drop in the same clock that the fault latches.
    assign fault_next = fault_q | overtime_a | overtime_b;

    // ====================
    // Switches and dead time
    // ====================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            h_q <= '0;
            l_q <= '0;
            fault_q <= 1'b0;
            for (int k = 0; k < 4; k++) begin
                off_h[k] <= '0;
                off_l[k] <= '0;
            end
        end else begin
            fault_q <= fault_next;
            for (int k = 0; k < 4; k++) begin
                h_q[k] <= want_h[k] && !fault_next && (h_q[k] ||
                    (!l_q[k] && off_l[k] == stepper_pkg::dead_count_t'(stepper_pkg::dead_cycles - 1)));
                l_q[k] <= want_l[k] && !fault_next && (l_q[k] ||
                    (!h_q[k] && off_h[k] == stepper_pkg::dead_count_t'(stepper_pkg::dead_cycles - 1)));
                if (h_q[k]) begin
                    off_h[k] <= '0;
                end else if (off_h[k] != stepper_pkg::dead_count_t'(stepper_pkg::dead_cycles - 1)) begin
                    off_h[k] <= off_h[k] + 1'b1;
                end
                if (l_q[k]) begin
                    off_l[k] <= '0;
                end else if (off_l[k] != stepper_pkg::dead_count_t'(stepper_pkg::dead_cycles - 1)) begin
                    off_l[k] <= off_l[k] + 1'b1;
                end
            end
        end
    end

    // Charge pump clock toggles once per period.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cp_count <= '0;
            cp_q <= 1'b0;
        end else if (cp_count == chargepump_period - 1'b1) begin
            cp_count <= '0;
            cp_q <= ~cp_q;
        end else begin
            cp_count <= cp_count + 1'b1;
        end
    end

    assign s_h = h_q ^ {4{invert_highside}};
    assign s_l = l_q ^ {4{invert_lowside}};
    assign chargepump_pin = cp_q;
    assign fault = fault_q;

endmodule

// File: source/microstepper_top.sv
`timescale 1ns/1ps

module microstepper_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      step,
    input  logic                      dir,
    input  logic                      enable,
    input  stepper_pkg::chop_config_t chop_config,
    input  stepper_pkg::short_time_t  chargepump_period,
    input  logic                      invert_highside,
    input  logic                      invert_lowside,
    input  logic                      analog_cmp1,
    input  logic                      analog_cmp2,
    output logic [3:0]                s_h,
    output logic [3:0]                s_l,
    output logic                      analog_out1,
    output logic                      analog_out2,
    output logic                      chargepump_pin,
    output logic                      fault
);

    stepper_pkg::coil_target_t target_a;
    stepper_pkg::coil_target_t target_b;
    stepper_pkg::bridge_mode_t mode_a;
    stepper_pkg::bridge_mode_t mode_b;
    logic overtime_a;
    logic overtime_b;

    step_sequencer step_sequencer_i (
        .clk      (clk),
        .resetn   (resetn),
        .step     (step),
        .dir      (dir),
        .enable   (enable),
        .target_a (target_a),
        .target_b (target_b)
    );

    // ====================
    // Coil A
    // ====================

    reference_pwm reference_pwm_a (
        .clk    (clk),
        .resetn (resetn),
        .duty   (target_a.magnitude),
        .pwm    (analog_out1)
    );

    coil_chopper coil_chopper_a (
        .clk          (clk),
        .resetn       (resetn),
        .enable       (enable),
        .target       (target_a),
        .chop_config  (chop_config),
        .over_current (analog_cmp1),
        .mode         (mode_a),
        .overtime     (overtime_a)
    );

    // ====================
    // Coil B
    // ====================

    reference_pwm reference_pwm_b (
        .clk    (clk),
        .resetn (resetn),
        .duty   (target_b.magnitude),
        .pwm    (analog_out2)
    );

    coil_chopper coil_chopper_b (
        .clk          (clk),
        .resetn       (resetn),
        .enable       (enable),
        .target       (target_b),
        .chop_config  (chop_config),
        .over_current (analog_cmp2),
        .mode         (mode_b),
        .overtime     (overtime_b)
    );

    gate_drive gate_drive_i (
        .clk               (clk),
        .resetn            (resetn),
        .mode_a            (mode_a),
        .mode_b            (mode_b),
        .overtime_a        (overtime_a),
        .overtime_b        (overtime_b),
        .chargepump_period (chargepump_period),
        .invert_highside   (invert_highside),
        .invert_lowside    (invert_lowside),
        .s_h               (s_h),
        .s_l               (s_l),
        .chargepump_pin    (chargepump_pin),
        .fault             (fault)
    );

endmodule

// File: verif/coil_model.sv
`timescale 1ns/1ps

module coil_model (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [1:0]            high,
    input  logic [1:0]            low,
    output stepper_pkg::current_t current
);

    logic [1:0] prescale;
    logic driven;

    // Either diagonal of the bridge puts the supply across the coil.
    assign driven = (high[0] && low[1]) || (high[1] && low[0]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prescale <= '0;
            current <= '0;
        end else begin
            prescale <= prescale + 2'd1; // One current step every 4 clocks.
            if (prescale == 2'd3) begin
                if (driven) begin
                    if (current != 8'hff) begin
                        current <= current + 8'd1;
                    end
                end else if (current != 8'h00) begin
                    current <= current - 8'd1; // Decay with the bridge open or shorted.
                end
            end
        end
    end

endmodule

// File: verif/microstepper_tb.sv
`timescale 1ns/1ps

module microstepper_tb;

    localparam int timeout_cycles = 200000; // Far above the roughly 10000 cycles of all tests.
    localparam int tolerance = stepper_pkg::dead_cycles + 2;
    localparam int fault_limit = stepper_pkg::max_on_cycles + stepper_pkg::dead_cycles + 4;

    logic clk = 1'b0;
    logic resetn;
    logic step;
    logic dir;
    logic enable;
    stepper_pkg::chop_config_t chop_config;
    stepper_pkg::short_time_t chargepump_period;
    logic invert_highside;
    logic invert_lowside;
    logic analog_cmp1;
    logic analog_cmp2;
    logic [3:0] s_h;
    logic [3:0] s_l;
    logic analog_out1;
    logic analog_out2;
    logic chargepump_pin;
    logic fault;

    logic [3:0] gate_h;
    logic [3:0] gate_l;
    stepper_pkg::current_t current_a;
    stepper_pkg::current_t current_b;
    stepper_pkg::current_t ref_a;
    stepper_pkg::current_t ref_b;
    logic [8:0] high_a;
    logic [8:0] high_b;
    logic [7:0] window_count;
    logic force_cmp1_low;
    int cycle_count = 0;

    always #4 clk = ~clk;

    microstepper_top microstepper_top_i (
        .clk               (clk),
        .resetn            (resetn),
        .step              (step),
        .dir               (dir),
        .enable            (enable),
        .chop_config       (chop_config),
        .chargepump_period (chargepump_period),
        .invert_highside   (invert_highside),
        .invert_lowside    (invert_lowside),
        .analog_cmp1       (analog_cmp1),
        .analog_cmp2       (analog_cmp2),
        .s_h               (s_h),
        .s_l               (s_l),
        .analog_out1       (analog_out1),
        .analog_out2       (analog_out2),
        .chargepump_pin    (chargepump_pin),
        .fault             (fault)
    );

    // ====================
    // Coil and comparator models
    // ====================

    assign gate_h = s_h ^ {4{invert_highside}}; // Switch states before inversion.
    assign gate_l = s_l ^ {4{invert_lowside}};

    coil_model coil_a (
        .clk     (clk),
        .resetn  (resetn),
        .high    (gate_h[1:0]),
        .low     (gate_l[1:0]),
        .current (current_a)
    );

    coil_model coil_b (
        .clk     (clk),
        .resetn  (resetn),
        .high    (gate_h[3:2]),
        .low     (gate_l[3:2]),
        .current (current_b)
    );

    // The reference voltage is the PWM high count of the last full period.
    always @(posedge clk) begin
        if (!resetn) begin
            window_count <= '0;
            high_a <= '0;
            high_b <= '0;
            ref_a <= '0;
            ref_b <= '0;
        end else begin
            window_count <= window_count + 8'd1;
            if (window_count == 8'd255) begin
                ref_a <= 8'(high_a + {8'd0, analog_out1});
                ref_b <= 8'(high_b + {8'd0, analog_out2});
                high_a <= '0;
                high_b <= '0;
            end else begin
                high_a <= high_a + {8'd0, analog_out1};
                high_b <= high_b + {8'd0, analog_out2};
            end
        end
    end

    assign analog_cmp1 = !force_cmp1_low && (current_a > ref_a);
    assign analog_cmp2 = current_b > ref_b;

    // ====================
    // Checking
    // ====================

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected, input int limit);
        int diff;
        diff = int'(actual) - int'(expected);
        if (diff < 0) begin
            diff = -diff;
        end
        if ($isunknown(actual) || diff > limit) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    always @(negedge clk) begin
        check("bridge leg overlap", 32'(gate_h & gate_l), 0, 0); // Never high and low together.
    end

    // Coil current magnitude from the sine rule with quadrant folding.
    function automatic int expected_magnitude(input int phase);
        int quadrant;
        int idx;
        quadrant = phase / 32;
        idx = phase % 32;
        if (quadrant == 1 || quadrant == 3) begin
            idx = 32 - idx;
        end
        return $rtoi(255.0 * $sin(3.14159265358979 / 2.0 * idx / 32.0) + 0.5);
    endfunction

    // ====================
    // Stimulus helpers
    // ====================

    task automatic apply_reset();
        @(posedge clk);
        resetn <= 1'b0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
    endtask

    task automatic issue_steps(input int count, input logic direction);
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            dir <= direction;
            step <= 1'b1;
            repeat (2) @(posedge clk);
            step <= 1'b0;
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_targets(input int phase);
        int high_1;
        int high_2;
        high_1 = 0;
        high_2 = 0;
        repeat (300) @(negedge clk); // New duty is latched within one PWM period.
        repeat (256) begin
            @(negedge clk);
            high_1 += int'(analog_out1);
            high_2 += int'(analog_out2);
        end
        check("analog_out1 high count", high_1, expected_magnitude(phase), 0);
        check("analog_out2 high count", high_2, expected_magnitude((phase + 32) % 128), 0);
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_reset();
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check("s_h", 32'(s_h), 0, 0);
        check("s_l", 32'(s_l), 0, 0);
        check("fault", 32'(fault), 0, 0);
        check("analog_out1", 32'(analog_out1), 0, 0);
        check("analog_out2", 32'(analog_out2), 0, 0);
        check("chargepump_pin", 32'(chargepump_pin), 0, 0);
        @(posedge clk);
        invert_highside <= 1'b1;
        invert_lowside <= 1'b1;
        @(negedge clk);
        check("s_h inverted", 32'(s_h), 15, 0);
        check("s_l inverted", 32'(s_l), 15, 0);
        @(posedge clk);
        invert_highside <= 1'b0;
        invert_lowside <= 1'b0;
    endtask

    task automatic test_microsteps();
        int count;
        count = 1 + int'($urandom % 40);
        @(posedge clk);
        enable <= 1'b1;
        issue_steps(count, 1'b1);
        enable <= 1'b0; // Idle choppers while the references are measured.
        check_targets(count);
        @(posedge clk);
        enable <= 1'b1;
        issue_steps(count, 1'b0);
        enable <= 1'b0;
        check_targets(0);
        issue_steps(5, 1'b1);
        check_targets(0);
        check("fault", 32'(fault), 0, 0);
    endtask

    task automatic test_chopping();
        int off_cycles;
        int reverse_cycles;
        int slow_cycles;
        apply_reset();
        @(posedge clk);
        enable <= 1'b1;
        issue_steps(16, 1'b1); // Quadrant 0, coil B is positive.
        @(negedge clk);
        while (s_h[2] !== 1'b1) @(negedge clk);
        check("s_l[3] during forward drive", 32'(s_l[3]), 1, 0);
        while (s_h[2] === 1'b1) @(negedge clk);
        off_cycles = 0;
        reverse_cycles = 0;
        slow_cycles = 0;
        while (s_h[2] !== 1'b1) begin
            if (s_h[3] === 1'b1) begin
                reverse_cycles++;
            end
            if (s_l[2] === 1'b1 && s_l[3] === 1'b1) begin
                slow_cycles++; // Both low sides on.
            end
            off_cycles++;
            @(negedge clk);
        end
        check("s_l[3] after off period", 32'(s_l[3]), 1, 0);
        check("fast decay gate cycles", reverse_cycles, 32'(chop_config.fastdecay_time), tolerance);
        check("slow decay gate cycles", slow_cycles,
              32'(chop_config.offtime - chop_config.fastdecay_time), tolerance);
        check("off period cycles", off_cycles, 32'(chop_config.offtime), tolerance);
    endtask

    task automatic test_fault();
        int waited;
        apply_reset();
        @(posedge clk);
        force_cmp1_low <= 1'b1;
        enable <= 1'b1;
        issue_steps(16, 1'b1);
        @(negedge clk);
        while (s_h[0] !== 1'b1) @(negedge clk);
        waited = 0;
        while (fault !== 1'b1 && waited < fault_limit) begin
            @(negedge clk);
            waited++;
        end
        if (fault !== 1'b1) begin
            $display("The fault output did not rise within %0d cycles of coil A drive", fault_limit);
            stop_with_failure();
        end
        repeat (500) begin
            check("s_h during fault", 32'(s_h), 0, 0);
            check("s_l during fault", 32'(s_l), 0, 0);
            check("fault", 32'(fault), 1, 0);
            @(negedge clk);
        end
        @(posedge clk);
        force_cmp1_low <= 1'b0;
        enable <= 1'b0;
        apply_reset();
        @(negedge clk);
        check("fault after reset", 32'(fault), 0, 0);
        check("s_h after reset", 32'(s_h), 0, 0);
        check("s_l after reset", 32'(s_l), 0, 0);
    endtask

    task automatic test_charge_pump();
        int gap;
        logic level;
        @(negedge clk);
        level = chargepump_pin;
        while (chargepump_pin == level) @(negedge clk);
        repeat (3) begin
            level = chargepump_pin;
            gap = 0;
            while (chargepump_pin == level) begin
                @(negedge clk);
                gap++;
            end
            check("chargepump_pin edge spacing", gap, 32'(chargepump_period), 0);
        end
    endtask

    initial begin
        int seed_result;
        seed_result = $urandom(19);
        resetn = 1'b0;
        step = 1'b0;
        dir = 1'b0;
        enable = 1'b0;
        chop_config.offtime = 10'd200;
        chop_config.blanktime = 8'd20;
        chop_config.fastdecay_time = 10'd60;
        chop_config.min_on_time = 8'd30;
        chargepump_period = 8'd91;
        invert_highside = 1'b0;
        invert_lowside = 1'b0;
        force_cmp1_low = 1'b0;

        test_reset();
        test_microsteps();
        test_chopping();
        test_fault();
        test_charge_pump();

        $display("All checks passed");
        $finish;
    end

endmodule

// File: microstepper_top.f
source/stepper_pkg.sv
source/step_sequencer.sv
source/reference_pwm.sv
source/coil_chopper.sv
source/gate_drive.sv
source/microstepper_top.sv
verif/coil_model.sv
verif/microstepper_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module microstepper_tb -f microstepper_top.f

output=$(./obj_dir/Vmicrostepper_tb) || true
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
